//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire opcode_t               opcode,
  input  wire logic [word_width-1:0] a,
  input  wire logic [word_width-1:0] b,
  input  wire logic [3:0]            shamt,
  output logic [word_width-1:0]      result,
  output logic                       flag_z,
  output logic                       flag_v,
  output logic                       flag_n
);

  logic [word_width-1:0]   sum;
  logic [word_width-1:0]   diff;
  logic [2*word_width-1:0] rot;
  logic                    ovf;
  logic                    arith_op;

  assign sum  = a + b;
  assign diff = a - b;
  // doubled operand so a right shift gives the rotate
  assign rot  = {a, a} >> shamt;

  always_comb begin
    case (opcode)
      op_add:  result = sum;
      op_sub:  result = diff;
      op_xor:  result = a ^ b;
      op_and:  result = a & b;
      op_sll:  result = a << shamt;
      op_sra:  result = $signed(a) >>> shamt;
      op_ror:  result = rot[word_width-1:0];
      default: result = a | b;
    endcase
  end

  // signed overflow, operand signs vs result sign
  always_comb begin
    if (opcode == op_sub) begin
      ovf = (a[15] != b[15]) && (diff[15] != a[15]);
    end else begin
      ovf = (a[15] == b[15]) && (sum[15] != a[15]);
    end
  end

  // add and sub update all three flags
  assign arith_op = (opcode == op_add) || (opcode == op_sub);

  always_ff @(posedge clk) begin
    if (reset) begin
      flag_z <= 1'b0;
      flag_v <= 1'b0;
      flag_n <= 1'b0;
    end else if (!opcode[3]) begin
      // every alu group op sets z
      flag_z <= (result == '0);
      if (arith_op) begin
        flag_v <= ovf;
        flag_n <= result[15];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       imem_we,
  input  wire logic [imem_addr_width-1:0] imem_addr,
  input  wire logic [word_width-1:0]      imem_wdata,
  output logic                            hlt,
  output logic [word_width-1:0]           pc,
  output logic                            wb_en,
  output logic [reg_sel_width-1:0]        wb_reg,
  output logic [word_width-1:0]           wb_data
);

  logic [word_width-1:0]    instr;
  logic [word_width-1:0]    pc_plus2;
  opcode_t                  opcode;
  logic [reg_sel_width-1:0] rd;
  logic [reg_sel_width-1:0] rs;
  logic [reg_sel_width-1:0] rt;
  logic [7:0]               imm8;
  logic [3:0]               mem_off;
  cond_t                    cond;
  logic [8:0]               branch_off;
  logic                     branch;
  logic                     branch_reg;
  logic                     reg_we;
  logic                     mem_we;
  wb_sel_t                  wb_sel;
  logic [word_width-1:0]    rs_data;
  logic [word_width-1:0]    rt_data;
  logic [word_width-1:0]    alu_result;
  logic                     flag_z;
  logic                     flag_v;
  logic                     flag_n;

  // write-back strobe, quiet while in reset
  assign wb_en  = reg_we & ~reset;
  assign wb_reg = rd;

  // pc, next pc and program memory
  fetch_unit i_fetch (
    .clk(clk), .reset(reset), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .branch(branch), .branch_reg(branch_reg), .halt(hlt),
    .cond(cond), .branch_off(branch_off), .rs_data(rs_data), .flag_z(flag_z),
    .flag_v(flag_v), .flag_n(flag_n), .pc(pc), .pc_plus2(pc_plus2), .instr(instr)
  );

  decode_unit i_decode (
    .instr(instr), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt), .imm8(imm8),
    .mem_off(mem_off), .cond(cond), .branch_off(branch_off), .branch(branch),
    .branch_reg(branch_reg), .halt(hlt), .reg_we(reg_we), .mem_we(mem_we),
    .wb_sel(wb_sel)
  );

  register_file i_regs (
    .clk(clk), .reset(reset), .we(wb_en), .rs(rs), .rt(rt), .rd(rd),
    .wdata(wb_data), .rs_data(rs_data), .rt_data(rt_data)
  );

  // shift amount sits in the rt field
  alu i_alu (
    .clk(clk), .reset(reset), .opcode(opcode), .a(rs_data), .b(rt_data),
    .shamt(rt), .result(alu_result), .flag_z(flag_z), .flag_v(flag_v),
    .flag_n(flag_n)
  );

  // opcode lsb tells lhb from llb
  memory_stage i_mem (
    .clk(clk), .reset(reset), .mem_we(mem_we), .base(rs_data), .mem_off(mem_off),
    .store_data(rt_data), .alu_result(alu_result), .imm8(imm8), .old_rd(rs_data),
    .byte_high(instr[12]), .pc_plus2(pc_plus2), .wb_sel(wb_sel), .wb_data(wb_data)
  );

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath and instruction width
  localparam int word_width = 16;
  // register number width, 16 registers
  localparam int reg_sel_width = 4;

  // program memory, word indexed
  localparam int imem_depth = 256;
  localparam int imem_addr_width = 8;

  // data memory, word indexed
  localparam int dmem_depth = 256;
  localparam int dmem_addr_width = 8;

  // opcodes, instr[15:12]
  // 0..7 are the alu group, msb clear
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_xor = 4'd2,
    op_and = 4'd3,
    op_sll = 4'd4,
    op_sra = 4'd5,
    op_ror = 4'd6,
    op_or  = 4'd7,
    op_lw  = 4'd8,
    op_sw  = 4'd9,
    op_llb = 4'd10,
    op_lhb = 4'd11,
    op_b   = 4'd12,
    op_br  = 4'd13,
    op_pcs = 4'd14,
    op_hlt = 4'd15
  } opcode_t;

  // branch conditions, instr[11:9]
  typedef enum logic [2:0] {
    cond_ne = 3'd0,
    cond_eq = 3'd1,
    cond_gt = 3'd2,
    cond_lt = 3'd3,
    cond_ge = 3'd4,
    cond_le = 3'd5,
    cond_ov = 3'd6,
    cond_al = 3'd7
  } cond_t;

  // write-back source select
  typedef enum logic [1:0] {
    wb_alu = 2'd0,
    wb_mem = 2'd1,
    wb_imm = 2'd2,
    wb_pc  = 2'd3
  } wb_sel_t;

endpackage

`default_nettype wire

//--- rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import cpu_pkg::*; (
  input  wire logic [word_width-1:0] instr,
  output opcode_t                    opcode,
  output logic [reg_sel_width-1:0]   rd,
  output logic [reg_sel_width-1:0]   rs,
  output logic [reg_sel_width-1:0]   rt,
  output logic [7:0]                 imm8,
  output logic [3:0]                 mem_off,
  output cond_t                      cond,
  output logic [8:0]                 branch_off,
  output logic                       branch,
  output logic                       branch_reg,
  output logic                       halt,
  output logic                       reg_we,
  output logic                       mem_we,
  output wb_sel_t                    wb_sel
);

  assign opcode = opcode_t'(instr[15:12]);

  // fixed fields
  assign rd         = instr[11:8];
  assign imm8       = instr[7:0];
  assign mem_off    = instr[3:0];
  assign cond       = cond_t'(instr[11:9]);
  assign branch_off = instr[8:0];

  // byte immediates read old rd on the first port
  assign rs = (opcode == op_llb || opcode == op_lhb) ? instr[11:8] : instr[7:4];
  // store data comes through the second port
  assign rt = (opcode == op_sw) ? instr[11:8] : instr[3:0];

  always_comb begin
    branch     = 1'b0;
    branch_reg = 1'b0;
    halt       = 1'b0;
    reg_we     = 1'b0;
    mem_we     = 1'b0;
    wb_sel     = wb_alu;
    case (opcode)
      op_lw: begin
        reg_we = 1'b1;
        wb_sel = wb_mem;
      end
      op_sw:  mem_we = 1'b1;
      op_llb, op_lhb: begin
        reg_we = 1'b1;
        wb_sel = wb_imm;
      end
      op_b:   branch = 1'b1;
      op_br:  branch_reg = 1'b1;
      op_pcs: begin
        reg_we = 1'b1;
        wb_sel = wb_pc;
      end
      op_hlt: halt = 1'b1;
      // alu group writes the alu result
      default: reg_we = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       imem_we,
  input  wire logic [imem_addr_width-1:0] imem_addr,
  input  wire logic [word_width-1:0]      imem_wdata,
  input  wire logic                       branch,
  input  wire logic                       branch_reg,
  input  wire logic                       halt,
  input  wire cond_t                      cond,
  input  wire logic [8:0]                 branch_off,
  input  wire logic [word_width-1:0]      rs_data,
  input  wire logic                       flag_z,
  input  wire logic                       flag_v,
  input  wire logic                       flag_n,
  output logic [word_width-1:0]           pc,
  output logic [word_width-1:0]           pc_plus2,
  output logic [word_width-1:0]           instr
);

  logic [word_width-1:0] imem [imem_depth];
  logic [word_width-1:0] pc_next;
  logic [word_width-1:0] branch_target;
  logic                  taken;

  // program memory, loaded only while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // byte address to word index, bit 0 dropped
  assign instr = imem[pc[imem_addr_width:1]];

  assign pc_plus2 = pc + 16'd2;
  // signed word offset, relative to the next instruction
  assign branch_target = pc_plus2 + {{6{branch_off[8]}}, branch_off, 1'b0};

  // condition test against the current flags
  always_comb begin
    case (cond)
      cond_ne: taken = !flag_z;
      cond_eq: taken = flag_z;
      cond_gt: taken = !flag_z && !flag_n;
      cond_lt: taken = flag_n;
      cond_ge: taken = flag_z || !flag_n;
      cond_le: taken = flag_z || flag_n;
      cond_ov: taken = flag_v;
      default: taken = 1'b1;
    endcase
  end

  always_comb begin
    if (halt) begin
      // hlt parks the pc on itself
      pc_next = pc;
    end else if (branch && taken) begin
      pc_next = branch_target;
    end else if (branch_reg && taken) begin
      pc_next = rs_data;
    end else begin
      pc_next = pc_plus2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // program loading belongs to reset only
  a_imem_we_in_reset: assert property (@(posedge clk) imem_we |-> reset);
  // register branch targets must stay word aligned too
  a_pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  mem_we,
  input  wire logic [word_width-1:0] base,
  input  wire logic [3:0]            mem_off,
  input  wire logic [word_width-1:0] store_data,
  input  wire logic [word_width-1:0] alu_result,
  input  wire logic [7:0]            imm8,
  input  wire logic [word_width-1:0] old_rd,
  input  wire logic                  byte_high,
  input  wire logic [word_width-1:0] pc_plus2,
  input  wire wb_sel_t               wb_sel,
  output logic [word_width-1:0]      wb_data
);

  logic [word_width-1:0]      dmem [dmem_depth];
  logic [word_width-1:0]      data_addr;
  logic [dmem_addr_width-1:0] dmem_idx;
  logic [word_width-1:0]      rd_data;
  logic [word_width-1:0]      imm_merged;

  // base plus signed word offset, byte address
  assign data_addr = base + {{11{mem_off[3]}}, mem_off, 1'b0};
  assign dmem_idx  = data_addr[dmem_addr_width:1];

  always_ff @(posedge clk) begin
    if (mem_we && !reset) begin
      dmem[dmem_idx] <= store_data;
    end
  end

  assign rd_data = dmem[dmem_idx];

  // lhb keeps the low byte, llb keeps the high byte
  assign imm_merged = byte_high ? {imm8, old_rd[7:0]} : {old_rd[15:8], imm8};

  always_comb begin
    case (wb_sel)
      wb_mem:  wb_data = rd_data;
      wb_imm:  wb_data = imm_merged;
      wb_pc:   wb_data = pc_plus2;
      default: wb_data = alu_result;
    endcase
  end

  // an odd base register would tear a store across two words
  a_store_aligned: assert property (
    @(posedge clk) disable iff (reset) mem_we |-> data_addr[0] == 1'b0);

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     we,
  input  wire logic [reg_sel_width-1:0] rs,
  input  wire logic [reg_sel_width-1:0] rt,
  input  wire logic [reg_sel_width-1:0] rd,
  input  wire logic [word_width-1:0]    wdata,
  output logic [word_width-1:0]         rs_data,
  output logic [word_width-1:0]         rt_data
);

  logic [word_width-1:0]    regs [2**reg_sel_width];
  // walks the registers while reset is held
  logic [reg_sel_width-1:0] clr_cnt;

  always_ff @(posedge clk) begin
    if (!reset) begin
      clr_cnt <= '0;
    end else begin
      clr_cnt <= clr_cnt + 1'b1;
    end
  end

  // one register cleared per reset cycle, all 16 after 16 cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      regs[clr_cnt] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // register 0 is hardwired to zero
  assign rs_data = (rs == '0) ? '0 : regs[rs];
  assign rt_data = (rt == '0) ? '0 : regs[rt];

  // the top level must gate the write enable with reset
  a_no_write_in_reset: assert property (@(posedge clk) reset |-> !we);

endmodule

`default_nettype wire

//--- test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int num_regs = 16;
  localparam int hlt_timeout = 2000;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [15:0] imem_wdata;
  logic        hlt;
  logic [15:0] pc;
  logic        wb_en;
  logic [3:0]  wb_reg;
  logic [15:0] wb_data;

  // program image shared by the dut load and the model
  logic [15:0] prog [imem_depth];
  int          prog_len;
  string       test_name;
  logic        running;

  // model state
  logic [15:0] m_regs [num_regs];
  logic [15:0] m_mem [dmem_depth];
  logic [15:0] m_pc;
  logic        m_z;
  logic        m_v;
  logic        m_n;
  // expected outputs for the current cycle
  logic        exp_wb_en;
  logic [3:0]  exp_wb_reg;
  logic [15:0] exp_wb_data;
  logic        exp_hlt;

  cpu i_dut (
    .clk(clk), .reset(reset), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .hlt(hlt), .pc(pc), .wb_en(wb_en), .wb_reg(wb_reg),
    .wb_data(wb_data)
  );

  always #10 clk = ~clk;

  // x bits in the expected value are don't care
  task automatic check(input string what, input logic [15:0] expected,
                       input logic [15:0] actual);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (expected[i] !== 1'bx && actual[i] !== expected[i]) begin
        bad = 1'b1;
      end
    end
    if (bad) begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  function automatic logic [15:0] reg_read(input logic [3:0] r);
    return (r == 4'd0) ? 16'h0000 : m_regs[r];
  endfunction

  function automatic logic cond_true(input logic [2:0] c);
    case (c)
      cond_ne: return !m_z;
      cond_eq: return m_z;
      cond_gt: return !m_z && !m_n;
      cond_lt: return m_n;
      cond_ge: return m_z || !m_n;
      cond_le: return m_z || m_n;
      cond_ov: return m_v;
      default: return 1'b1;
    endcase
  endfunction

  // instruction set model that retires one instruction per call
  function automatic void model_step(input logic [15:0] ins);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] old;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] next_pc;
    int          sum;
    int          sa;
    int          sb;
    op = ins[15:12];
    rd = ins[11:8];
    a = reg_read(ins[7:4]);
    b = reg_read(ins[3:0]);
    old = reg_read(rd);
    addr = a + {{11{ins[3]}}, ins[3:0], 1'b0};
    next_pc = m_pc + 16'd2;
    exp_wb_en = 1'b0;
    exp_wb_reg = rd;
    exp_wb_data = 16'h0000;
    exp_hlt = 1'b0;
    res = 16'h0000;
    case (op)
      op_add, op_sub: begin
        // signed overflow from the true integer result
        sa = $signed(a);
        sb = $signed(b);
        sum = (op == op_add) ? sa + sb : sa - sb;
        res = sum[15:0];
        m_v = (sum > 32767) || (sum < -32768);
        m_n = res[15];
      end
      op_xor: res = a ^ b;
      op_and: res = a & b;
      op_or:  res = a | b;
      op_sll: res = a << ins[3:0];
      op_sra: res = 16'($signed(a) >>> ins[3:0]);
      op_ror: begin
        res = a;
        for (int i = 0; i < ins[3:0]; i++) begin
          res = {res[0], res[15:1]};
        end
      end
      op_lw: begin
        exp_wb_en = 1'b1;
        exp_wb_data = m_mem[addr[8:1]];
      end
      op_sw:  m_mem[addr[8:1]] = old;
      op_llb: begin
        exp_wb_en = 1'b1;
        exp_wb_data = {old[15:8], ins[7:0]};
      end
      op_lhb: begin
        exp_wb_en = 1'b1;
        exp_wb_data = {ins[7:0], old[7:0]};
      end
      op_b: begin
        if (cond_true(ins[11:9])) begin
          next_pc = m_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
        end
      end
      op_br: begin
        if (cond_true(ins[11:9])) begin
          next_pc = a;
        end
      end
      op_pcs: begin
        exp_wb_en = 1'b1;
        exp_wb_data = m_pc + 16'd2;
      end
      default: begin
        // hlt parks the pc
        next_pc = m_pc;
        exp_hlt = 1'b1;
      end
    endcase
    // alu group is opcodes 0 to 7
    if (!op[3]) begin
      m_z = (res == 16'h0000);
      exp_wb_en = 1'b1;
      exp_wb_data = res;
    end
    if (exp_wb_en && rd != 4'd0) begin
      m_regs[rd] = exp_wb_data;
    end
    m_pc = next_pc;
  endfunction

  // compare the dut against the model at each rising edge
  always @(posedge clk) begin
    if (reset) begin
      check("wb_en in reset", 16'h0000, {15'h0, wb_en});
    end else if (running) begin
      check("pc", m_pc, pc);
      model_step(prog[m_pc[8:1]]);
      check("wb_en", {15'h0, exp_wb_en}, {15'h0, wb_en});
      if (exp_wb_en) begin
        check("wb_reg", {12'h0, exp_wb_reg}, {12'h0, wb_reg});
        check("wb_data", exp_wb_data, wb_data);
      end
      check("hlt", {15'h0, exp_hlt}, {15'h0, hlt});
    end
  end

  task automatic new_program();
    prog_len = 0;
    // unused words hold hlt
    for (int i = 0; i < imem_depth; i++) begin
      prog[i] = {op_hlt, 12'h000};
    end
  endtask

  task automatic emit(input logic [15:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_const(input logic [3:0] r, input logic [15:0] value);
    emit({op_llb, r, value[7:0]});
    emit({op_lhb, r, value[15:8]});
  endtask

  // load the image during reset and then run until hlt
  task automatic run_program(input string name);
    int n;
    test_name = name;
    @(negedge clk);
    running = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < imem_depth; i++) begin
      imem_we = 1'b1;
      imem_addr = 8'(i);
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (4) @(negedge clk);
    m_pc = 16'h0000;
    m_z = 1'b0;
    m_v = 1'b0;
    m_n = 1'b0;
    for (int i = 0; i < num_regs; i++) begin
      m_regs[i] = 'x;
    end
    reset = 1'b0;
    running = 1'b1;
    check("pc after reset", 16'h0000, pc);
    n = 0;
    while (hlt !== 1'b1 && n < hlt_timeout) begin
      @(negedge clk);
      n++;
    end
    if (hlt !== 1'b1) begin
      $display("timeout in %s, hlt not reached within %0d cycles", name, hlt_timeout);
      $display("TESTS FAILED");
      $fatal(1, "hlt timeout");
    end
    // hlt must hold with the pc parked and no write-back
    repeat (10) @(negedge clk);
    running = 1'b0;
  endtask

  task automatic test_reset_state();
    new_program();
    emit({op_pcs, 4'd1, 8'h00});
    emit({op_hlt, 12'h000});
    run_program("reset_state");
  endtask

  task automatic test_alu_random();
    new_program();
    for (int r = 1; r < num_regs; r++) begin
      load_const(4'(r), 16'($urandom));
    end
    // r0 write is dropped and r0 then reads back as zero
    emit({op_add, 4'd0, 4'd1, 4'd2});
    emit({op_or, 4'd5, 4'd0, 4'd0});
    repeat (200) begin
      emit({4'($urandom_range(7, 0)), 4'($urandom), 4'($urandom), 4'($urandom)});
    end
    emit({op_hlt, 12'h000});
    run_program("alu_random");
  endtask

  task automatic test_load_store();
    new_program();
    load_const(4'd1, 16'h0040);
    load_const(4'd2, 16'h0050);
    load_const(4'd3, 16'ha5c3);
    load_const(4'd4, 16'h1234);
    load_const(4'd5, 16'h8001);
    emit({op_sw, 4'd3, 4'd1, 4'h3});
    emit({op_sw, 4'd4, 4'd1, 4'hc});
    emit({op_sw, 4'd5, 4'd1, 4'h0});
    emit({op_sw, 4'd4, 4'd2, 4'h7});
    // same word as r1+0 reached through the other base
    emit({op_sw, 4'd3, 4'd2, 4'h8});
    emit({op_sw, 4'd0, 4'd1, 4'h1});
    emit({op_lw, 4'd6, 4'd1, 4'h3});
    emit({op_lw, 4'd7, 4'd1, 4'hc});
    emit({op_lw, 4'd8, 4'd1, 4'h0});
    emit({op_lw, 4'd9, 4'd2, 4'h7});
    emit({op_lw, 4'd10, 4'd2, 4'h8});
    emit({op_lw, 4'd11, 4'd2, 4'hb});
    emit({op_lw, 4'd12, 4'd1, 4'h1});
    emit({op_hlt, 12'h000});
    run_program("load_store");
  endtask

  task automatic test_branches();
    new_program();
    load_const(4'd1, 16'h0001);
    load_const(4'd2, 16'h0050);
    load_const(4'd3, 16'h7000);
    // results that are zero then positive then negative then overflowing
    for (int s = 0; s < 4; s++) begin
      case (s)
        0: emit({op_sub, 4'd4, 4'd1, 4'd1});
        1: emit({op_add, 4'd4, 4'd1, 4'd2});
        2: emit({op_sub, 4'd4, 4'd1, 4'd2});
        default: emit({op_add, 4'd4, 4'd3, 4'd3});
      endcase
      // taken skips the llb marker
      for (int c = 0; c < 8; c++) begin
        emit({op_b, 3'(c), 9'd1});
        emit({op_llb, 4'd9, 8'(s * 16 + c)});
      end
    end
    // backward branch loop of three passes
    load_const(4'd5, 16'd3);
    emit({op_sub, 4'd5, 4'd5, 4'd1});
    emit({op_b, cond_ne, 9'h1fe});
    // with z set br ne falls through and br al jumps over the hlt
    load_const(4'd10, 16'(2 * (prog_len + 5)));
    emit({op_br, cond_ne, 1'b0, 4'd10, 4'h0});
    emit({op_br, cond_al, 1'b0, 4'd10, 4'h0});
    emit({op_hlt, 12'h000});
    emit({op_llb, 4'd11, 8'h77});
    emit({op_hlt, 12'h000});
    run_program("branches");
  endtask

  task automatic test_pcs_and_halt();
    new_program();
    emit({op_pcs, 4'd6, 8'h00});
    emit({op_pcs, 4'd0, 8'h00});
    load_const(4'd7, 16'h0102);
    emit({op_add, 4'd8, 4'd6, 4'd7});
    emit({op_pcs, 4'd15, 8'h00});
    emit({op_hlt, 12'h000});
    run_program("pcs_and_halt");
  endtask

  initial begin
    void'($urandom(32'h73d560e6));
    clk = 1'b0;
    reset = 1'b1;
    imem_we = 1'b0;
    imem_addr = 8'h00;
    imem_wdata = 16'h0000;
    running = 1'b0;
    test_name = "reset_state";
    for (int i = 0; i < dmem_depth; i++) begin
      m_mem[i] = 'x;
    end
    test_reset_state();
    test_alu_random();
    test_load_store();
    test_branches();
    test_pcs_and_halt();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/memory_stage.sv
rtl/cpu.sv
test/cpu_tb.sv
